//--- scadUnit.f
scadCromPkg.sv
scadDataPkg.sv
scadApbRegs.sv
scadCmdFifo.sv
scadExec.sv
scadUnit.sv
scadUnit_tb.sv
+incdir+.

//--- runSim.sh
#!/bin/sh
# Build and run the SCAD testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall -Wno-fatal \
   --top-module scadUnit_tb -f scadUnit.f -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simv
if [ $? -ne 0 ]; then
   echo "Simulation failed"
   exit 1
fi

exit 0

//--- scadUnit_tb.sv
/* SCAD peripheral testbench: clock, reset, APB tasks, reference
   model, compare process, FIFO level monitor and watchdog */
`timescale 1ns/1ns
`include "scadUnit_config.svh"

module scadUnit_tb;

   import scadDataPkg::*;

   // Upper bound on issued commands for the watchdog
   localparam int MAX_CMDS = 64;
   localparam int TIMEOUT_NS = (16 + 200 * MAX_CMDS) * 10;

   logic clk;
   logic rst;
   apbReq_t apb;
   logic [31:0] prdata;
   logic pready;
   logic pslverr;
   logic scSign;
   logic feSign;

   // In-order model of SC, FE and the last result
   logic [0:9] modelSc;
   logic [0:9] modelFe;
   logic [0:9] modelScad;
   int issued;
   logic [31:0] rngState;
   logic checkReq;

   scadUnit u_scadUnit
   (
      .clk     (clk),
      .rst     (rst),
      .apb     (apb),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .scSign  (scSign),
      .feSign  (feSign)
   );

   always #5 clk = ~clk;

   ////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] v;
      v = x ^ (x << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   task automatic reportMismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("Checks failed");
      $fatal(1);
   endtask

   // Pack fun, asel, bsel, snum, loadSc and loadFe into a microword
   function automatic logic [19:0] mkCrom(input int fun, input int asel, input int bsel,
                                          input logic [9:0] snum, input bit lsc, input bit lfe);
      return {fun[2:0], asel[2:0], bsel[1:0], snum, lsc, lfe};
   endfunction

   // Expected SCAD output from the select and function rules
   function automatic logic [0:9] refScad(input logic [19:0] crom, input logic [0:35] dp,
                                          input logic [0:9] sc, input logic [0:9] fe);
      logic [0:9] snum;
      logic [0:9] a;
      logic [0:9] b;
      snum = crom[11:2];
      case (crom[16:14])
         3'd0: a = sc;
         3'd1: a = snum;
         3'd2: a = {sc[0], 6'o44, dp[6], sc[8:9]};
         3'd3: a = {snum[0], dp[0:6], snum[8:9]};
         3'd4: a = {sc[0], dp[7:13], sc[8:9]};
         3'd5: a = {snum[0], dp[14:20], snum[8:9]};
         3'd6: a = {sc[0], dp[21:27], sc[8:9]};
         default: a = {snum[0], dp[28:34], snum[8:9]};
      endcase
      case (crom[13:12])
         2'd0: b = fe;
         2'd1: b = dp[0] ? {2'b00, ~dp[1:8]} : {2'b00, dp[1:8]};
         2'd2: b = {dp[18], dp[18], dp[28:35]};
         default: b = {1'b0, dp[6:11], 3'b000};
      endcase
      case (crom[19:17])
         3'd0: return a + a;
         3'd1: return a | b;
         3'd2: return a - b - 10'd1;
         3'd3: return a - b;
         3'd4: return a + b;
         3'd5: return a & b;
         3'd6: return a - 10'd1;
         default: return a;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////
   // APB transfers sampled at the falling edge
   ////////////////////////////////////////////////////////////////////

   task automatic apbXfer(input bit wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
      apb.psel = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite = wr;
      apb.paddr = addr;
      apb.pwdata = wdata;
      @(posedge clk);
      #1 apb.penable = 1'b1;
      do
         @(negedge clk);
      while (!pready);
      rdata = prdata;
      err = pslverr;
      @(posedge clk);
      #1 apb.psel = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
      logic [31:0] unused;
      apbXfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
      apbXfer(1'b0, addr, 32'h0, data, err);
   endtask

   task automatic issueCmd(input logic [0:35] dp, input logic [19:0] crom, input bit setDp);
      logic err;
      if (setDp)
         apbWrite(`SCAD_REG_DPLO, dp[4:35], err);
      apbWrite(`SCAD_REG_CMD, {8'h00, dp[0:3], crom}, err);
      assert (!err) else reportMismatch("pslverr", 0, err);
      modelScad = refScad(crom, dp, modelSc, modelFe);
      if (crom[1])
         modelSc = modelScad;
      if (crom[0])
         modelFe = modelScad;
      issued++;
   endtask

   task automatic requestCheck;
      checkReq = 1'b1;
      wait (!checkReq);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Compare process
   ////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [31:0] st;
      logic [31:0] res;
      logic err;
      forever
      begin
         wait (checkReq);
         do
            apbRead(`SCAD_REG_STATUS, st, err);
         while (st[15:0] != issued[15:0]);
         // Every issued command has executed, so the FIFO is drained
         assert (st[23:16] == 8'd0) else reportMismatch("status.level", 0, st[23:16]);
         apbRead(`SCAD_REG_RESULT, res, err);
         assert (!err) else reportMismatch("pslverr", 0, err);
         assert (res[29:20] == modelScad)
            else reportMismatch("result.scad", modelScad, res[29:20]);
         assert (res[19:10] == modelSc) else reportMismatch("result.sc", modelSc, res[19:10]);
         assert (res[9:0] == modelFe) else reportMismatch("result.fe", modelFe, res[9:0]);
         assert (st[27:24] == (modelScad[0] ? 4'b0010 : 4'b0000))
            else reportMismatch("status.dispatch", modelScad[0] ? 2 : 0, st[27:24]);
         assert (scSign == modelSc[0]) else reportMismatch("scSign", modelSc[0], scSign);
         assert (feSign == modelFe[0]) else reportMismatch("feSign", modelFe[0], feSign);
         checkReq = 1'b0;
      end
   end

   // FIFO level bound during back-pressure
   always @(negedge clk)
   begin
      assert (u_scadUnit.level <= `SCAD_FIFO_DEPTH)
         else reportMismatch("level", `SCAD_FIFO_DEPTH, u_scadUnit.level);
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("Timeout: the DUT stopped responding before the tests finished");
      $display("Checks failed");
      $fatal(1);
   end

   ////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [0:35] dp;
      logic err;
      logic [31:0] rd;
      clk = 1'b0;
      rst = 1'b1;
      apb = '0;
      modelSc = '0;
      modelFe = '0;
      modelScad = '0;
      issued = 0;
      rngState = 32'd91;
      checkReq = 1'b0;
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;

      // Functions on SC and FE with SC near the top to force wraparound
      issueCmd(36'h0, mkCrom(7, 1, 0, 10'h3F0, 1, 0), 1);
      issueCmd(36'h0, mkCrom(7, 1, 0, 10'h021, 0, 1), 0);
      for (int f = 0; f < 8; f++)
      begin
         issueCmd(36'h0, mkCrom(f, 0, 0, 10'h0, 0, 0), 0);
         requestCheck();
      end

      // A selects over a word with distinct fields
      dp = 36'h9A5C3E71B;
      issueCmd(dp, mkCrom(7, 1, 0, 10'h2C5, 1, 0), 1);
      for (int s = 0; s < 8; s++)
      begin
         issueCmd(dp, mkCrom(7, s, 0, 10'h283, 0, 0), 0);
         requestCheck();
      end

      // B selects with A = 0 and EXP seen with sign set and clear
      for (int s = 0; s < 4; s++)
      begin
         issueCmd(dp, mkCrom(4, 1, s, 10'h0, 0, 0), 0);
         requestCheck();
      end
      dp = 36'h3A7F4C2E5;
      issueCmd(dp, mkCrom(4, 1, 1, 10'h0, 0, 0), 1);
      requestCheck();
      issueCmd(dp, mkCrom(4, 1, 2, 10'h0, 0, 0), 0);
      requestCheck();

      // Load flags alone and together
      issueCmd(dp, mkCrom(7, 1, 0, 10'h201, 1, 0), 0);
      requestCheck();
      issueCmd(dp, mkCrom(7, 1, 0, 10'h355, 0, 1), 0);
      requestCheck();
      issueCmd(dp, mkCrom(7, 1, 0, 10'h0AA, 1, 1), 0);
      requestCheck();
      issueCmd(dp, mkCrom(7, 1, 0, 10'h0FF, 0, 0), 0);
      requestCheck();

      // Burst of 12 commands against an 8-deep FIFO
      rngState = xorshift(rngState);
      dp = {rngState[3:0], rngState};
      apbWrite(`SCAD_REG_DPLO, dp[4:35], err);
      for (int i = 0; i < 12; i++)
      begin
         rngState = xorshift(rngState);
         dp[0:3] = rngState[23:20];
         issueCmd(dp, rngState[19:0], 0);
      end
      requestCheck();

      // Bus errors
      apbRead(4'h2, rd, err);
      assert (err) else reportMismatch("pslverr", 1, err);
      apbWrite(`SCAD_REG_STATUS, 32'h1, err);
      assert (err) else reportMismatch("pslverr", 1, err);

      $display("All checks passed");
      $finish;
   end

endmodule

//--- scadUnit.sv
/* SCAD peripheral top: APB front end, command FIFO, executor */
`timescale 1ns/1ns
`include "scadUnit_config.svh"

module scadUnit
(
   input  logic                  clk,
   input  logic                  rst,
   input  scadDataPkg::apbReq_t  apb,
   output logic [31:0]           prdata,
   output logic                  pready,
   output logic                  pslverr,
   output logic                  scSign,
   output logic                  feSign
);

   import scadDataPkg::*;

   // Front end to FIFO
   logic                      push;
   scadCmd_t                  pushCmd;
   logic                      full;
   logic [`SCAD_LEVEL_W-1:0]  level;
   // FIFO to executor
   logic                      pop;
   scadCmd_t                  popCmd;
   logic                      empty;
   // Executor back to the readback registers
   scadResult_t               result;
   logic [15:0]               execCount;

   scadApbRegs u_scadApbRegs
   (
      .clk       (clk),
      .rst       (rst),
      .apb       (apb),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .full      (full),
      .level     (level),
      .push      (push),
      .pushCmd   (pushCmd),
      .result    (result),
      .execCount (execCount)
   );

   scadCmdFifo u_scadCmdFifo
   (
      .clk     (clk),
      .rst     (rst),
      .push    (push),
      .pushCmd (pushCmd),
      .full    (full),
      .pop     (pop),
      .popCmd  (popCmd),
      .empty   (empty),
      .level   (level)
   );

   scadExec u_scadExec
   (
      .clk       (clk),
      .rst       (rst),
      .popCmd    (popCmd),
      .empty     (empty),
      .pop       (pop),
      .result    (result),
      .execCount (execCount),
      .scSign    (scSign),
      .feSign    (feSign)
   );

endmodule

//--- scadExec.sv
/* SCAD executor: A and B operand muxes, eight-function ALU,
   SC and FE registers, result capture and command count */
`timescale 1ns/1ns

module scadExec
(
   input  logic                       clk,
   input  logic                       rst,
   input  scadDataPkg::scadCmd_t      popCmd,
   input  logic                       empty,
   output logic                       pop,
   output scadDataPkg::scadResult_t   result,
   output logic [15:0]                execCount,
   output logic                       scSign,
   output logic                       feSign
);

   import scadCromPkg::*;
   import scadDataPkg::*;

   // Step counter and floating-point exponent
   scad10_t sc;
   scad10_t fe;
   // Last ALU output
   scad10_t scadQ;

   scadCrom_t   crom;
   logic [0:35] dpBits;
   scad10_t     scadA;
   scad10_t     scadB;
   scad10_t     scad;

   assign crom = popCmd.crom;
   // Byte-pointer view as a flat word for the byte fields
   assign dpBits = popCmd.dp.ptr;

   // One command per cycle while any are queued
   assign pop = ~empty;

   //////////////////////////////////////////////////////////////////////
   // Operand selection
   //////////////////////////////////////////////////////////////////////

   // Odd bytes framed by SNUM edges, even bytes by SC edges
   always_comb
   begin
      case (crom.asel)
         SCAD_ASEL_SC:    scadA = sc;
         SCAD_ASEL_SNUM:  scadA = crom.snum;
         SCAD_ASEL_PTR44: scadA = {sc[0], 6'o44, popCmd.dp.ptr.size[0], sc[8:9]};
         SCAD_ASEL_BYTE1: scadA = {crom.snum[0], dpBits[0:6], crom.snum[8:9]};
         SCAD_ASEL_BYTE2: scadA = {sc[0], dpBits[7:13], sc[8:9]};
         SCAD_ASEL_BYTE3: scadA = {crom.snum[0], dpBits[14:20], crom.snum[8:9]};
         SCAD_ASEL_BYTE4: scadA = {sc[0], dpBits[21:27], sc[8:9]};
         SCAD_ASEL_BYTE5: scadA = {crom.snum[0], dpBits[28:34], crom.snum[8:9]};
      endcase
   end

   always_comb
   begin
      case (crom.bsel)
         SCAD_BSEL_FE:
            scadB = fe;
         // Negative numbers carry a ones-complement exponent
         SCAD_BSEL_EXP:
            scadB = popCmd.dp.flt.sign ? {2'b00, ~popCmd.dp.flt.exp}
                                       : {2'b00, popCmd.dp.flt.exp};
         // Bit 18 sign-extends the shift count in bits 28..35
         SCAD_BSEL_SHIFT:
            scadB = {popCmd.dp.ptr.y[0], popCmd.dp.ptr.y[0], popCmd.dp.ptr.y[10:17]};
         // Byte size times eight
         SCAD_BSEL_SIZE:
            scadB = {1'b0, popCmd.dp.ptr.size, 3'b000};
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // ALU, all arithmetic wraps at 10 bits
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (crom.fun)
         SCAD_FUN_A_PLUS_A:    scad = scadA + scadA;
         SCAD_FUN_A_OR_B:      scad = scadA | scadB;
         SCAD_FUN_A_MINUS_B_1: scad = scadA - scadB - 10'd1;
         SCAD_FUN_A_MINUS_B:   scad = scadA - scadB;
         SCAD_FUN_A_PLUS_B:    scad = scadA + scadB;
         SCAD_FUN_A_AND_B:     scad = scadA & scadB;
         SCAD_FUN_A_MINUS_1:   scad = scadA - 10'd1;
         SCAD_FUN_A:           scad = scadA;
      endcase
   end

   // Registers update on the pop edge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         sc        <= '0;
         fe        <= '0;
         scadQ     <= '0;
         execCount <= '0;
      end
      else if (pop)
      begin
         scadQ     <= scad;
         execCount <= execCount + 16'd1;
         if (crom.loadSc)
            sc <= scad;
         if (crom.loadFe)
            fe <= scad;
      end
   end

   assign result = '{scad: scadQ, sc: sc, fe: fe};
   assign scSign = sc[0];
   assign feSign = fe[0];

endmodule

//--- scadCmdFifo.sv
/* Circular command FIFO with occupancy count */
`timescale 1ns/1ns
`include "scadUnit_config.svh"

module scadCmdFifo
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       push,
   input  scadDataPkg::scadCmd_t      pushCmd,
   output logic                       full,
   input  logic                       pop,
   output scadDataPkg::scadCmd_t      popCmd,
   output logic                       empty,
   output logic [`SCAD_LEVEL_W-1:0]   level
);

   import scadDataPkg::*;

   localparam int DEPTH = `SCAD_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // Entry storage
   scadCmd_t mem [DEPTH];

   logic [PTR_W-1:0] wrPtr;
   logic [PTR_W-1:0] rdPtr;
   logic [`SCAD_LEVEL_W-1:0] count;
   logic doPush;
   logic doPop;

   // Guard against overflow and underflow
   assign doPush = push & ~full;
   assign doPop  = pop & ~empty;

   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= pushCmd;
   end

   // Pointers and occupancy, push and pop may coincide
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (doPush)
            wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop)
            rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         if (doPush & ~doPop)
            count <= count + 1'b1;
         else if (doPop & ~doPush)
            count <= count - 1'b1;
      end
   end

   // Head entry is always on the output
   assign popCmd = mem[rdPtr];
   assign empty  = (count == '0);
   assign full   = (count == `SCAD_LEVEL_W'(DEPTH));
   assign level  = count;

endmodule

//--- scadApbRegs.sv
/* APB register front end: DPLO holding register, command push
   with FIFO back-pressure, RESULT and STATUS readback */
`timescale 1ns/1ns
`include "scadUnit_config.svh"

module scadApbRegs
(
   input  logic                        clk,
   input  logic                        rst,
   input  scadDataPkg::apbReq_t        apb,
   output logic [31:0]                 prdata,
   output logic                        pready,
   output logic                        pslverr,
   input  logic                        full,
   input  logic [`SCAD_LEVEL_W-1:0]    level,
   output logic                        push,
   output scadDataPkg::scadCmd_t       pushCmd,
   input  scadDataPkg::scadResult_t    result,
   input  logic [15:0]                 execCount
);

   // Data-path bits 4 to 35 from the last DPLO write
   logic [4:35] dpLo;

   logic access;
   logic isDplo;
   logic isCmd;
   logic isResult;
   logic isStatus;
   logic accessErr;
   logic cmdWrite;
   logic [3:0] dispNib;

   //////////////////////////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////////////////////////

   // Access phase of a transfer
   assign access   = apb.psel & apb.penable;
   assign isDplo   = (apb.paddr == `SCAD_REG_DPLO);
   assign isCmd    = (apb.paddr == `SCAD_REG_CMD);
   assign isResult = (apb.paddr == `SCAD_REG_RESULT);
   assign isStatus = (apb.paddr == `SCAD_REG_STATUS);

   // Unknown offset, or write to a read-only register
   assign accessErr = ~(isDplo | isCmd | isResult | isStatus) |
                      (apb.pwrite & (isResult | isStatus));

   assign cmdWrite = access & apb.pwrite & isCmd;

   // CMD write waits in its access cycle until a slot frees
   assign pready  = access & ~(cmdWrite & full);
   assign pslverr = access & accessErr;

   //////////////////////////////////////////////////////////////////////
   // Command assembly
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dpLo <= '0;
      end
      else if (access & apb.pwrite & isDplo)
      begin
         dpLo <= apb.pwdata;
      end
   end

   // Push on the completing edge only
   assign push = cmdWrite & ~full;

   // Bits 23..20 carry data-path bits 0..3, low 20 bits the microword
   assign pushCmd.crom = apb.pwdata[19:0];
   assign pushCmd.dp   = {apb.pwdata[23:20], dpLo};

   //////////////////////////////////////////////////////////////////////
   // Readback
   //////////////////////////////////////////////////////////////////////

   // Dispatch on the sign of the last SCAD result
   assign dispNib = result.scad[0] ? 4'b0010 : 4'b0000;

   always_comb
   begin
      prdata = '0;
      if (isDplo)
         prdata = dpLo;
      else if (isResult)
         prdata = {2'b00, result};
      else if (isStatus)
         prdata = {4'b0000, dispNib, {(8 - `SCAD_LEVEL_W){1'b0}}, level, execCount};
   end

endmodule

//--- scadDataPkg.sv
/* Data-path word views, command and result records,
   APB request bundle */
`include "scadUnit_config.svh"

package scadDataPkg;

   // 10-bit SCAD quantity, bit 0 is the MSB
   typedef logic [0:9] scad10_t;

   // Byte-pointer layout: P, S, spare, I, X, Y
   typedef struct packed
   {
      logic [0:5]  pos;
      logic [0:5]  size;
      logic        spare;
      logic        ind;
      logic [0:3]  idx;
      logic [0:17] y;
   } dpPtr_t;

   // Single-precision float layout
   typedef struct packed
   {
      logic        sign;
      logic [0:7]  exp;
      logic [0:26] frac;
   } dpFloat_t;

   // One 36-bit data-path word, decoded either way
   typedef union packed
   {
      dpPtr_t   ptr;
      dpFloat_t flt;
   } dpWord_u;

   // Queued command, microword plus data-path operand (56 bits)
   typedef struct packed
   {
      scadCromPkg::scadCrom_t crom;
      dpWord_u                dp;
   } scadCmd_t;

   // Readback of the last executed command (30 bits)
   typedef struct packed
   {
      scad10_t scad;
      scad10_t sc;
      scad10_t fe;
   } scadResult_t;

   // Master-driven APB signals
   typedef struct packed
   {
      logic                    psel;
      logic                    penable;
      logic                    pwrite;
      logic [`SCAD_ADDR_W-1:0] paddr;
      logic [31:0]             pwdata;
   } apbReq_t;

endpackage

//--- scadCromPkg.sv
/* Microword field types, SCAD ALU function and
   A/B operand select encodings */
package scadCromPkg;

   // Small-number field, bit 0 is the MSB as on the original machine
   typedef logic [0:9] snum_t;

   // ALU function, order matches the microcode FUN field
   typedef enum logic [2:0]
   {
      SCAD_FUN_A_PLUS_A,
      SCAD_FUN_A_OR_B,
      SCAD_FUN_A_MINUS_B_1,
      SCAD_FUN_A_MINUS_B,
      SCAD_FUN_A_PLUS_B,
      SCAD_FUN_A_AND_B,
      SCAD_FUN_A_MINUS_1,
      SCAD_FUN_A
   } scadFun_e;

   // A operand source
   typedef enum logic [2:0]
   {
      SCAD_ASEL_SC,
      SCAD_ASEL_SNUM,
      SCAD_ASEL_PTR44,
      SCAD_ASEL_BYTE1,
      SCAD_ASEL_BYTE2,
      SCAD_ASEL_BYTE3,
      SCAD_ASEL_BYTE4,
      SCAD_ASEL_BYTE5
   } scadAsel_e;

   // B operand source
   typedef enum logic [1:0]
   {
      SCAD_BSEL_FE,
      SCAD_BSEL_EXP,
      SCAD_BSEL_SHIFT,
      SCAD_BSEL_SIZE
   } scadBsel_e;

   // SCAD slice of the microword, 20 bits
   typedef struct packed
   {
      scadFun_e  fun;
      scadAsel_e asel;
      scadBsel_e bsel;
      snum_t     snum;
      logic      loadSc;
      logic      loadFe;
   } scadCrom_t;

endpackage

//--- scadUnit_config.svh
/* SCAD peripheral build constants: command FIFO depth, level width,
   APB address width and register offsets */
`ifndef SCADUNIT_CONFIG_SVH
`define SCADUNIT_CONFIG_SVH

// Commands held between the APB front end and the executor
`define SCAD_FIFO_DEPTH 8

// Occupancy counter width, wide enough to hold a full FIFO
`define SCAD_LEVEL_W $clog2(`SCAD_FIFO_DEPTH + 1)

// APB byte address width
`define SCAD_ADDR_W 4

//////////////////////////////////////////////////////////////////////
// Register offsets
//////////////////////////////////////////////////////////////////////

`define SCAD_REG_DPLO   4'h0
`define SCAD_REG_CMD    4'h4
`define SCAD_REG_RESULT 4'h8
`define SCAD_REG_STATUS 4'hC

`endif
